/* uart_regbridge.f */
rtl/uart_regbridge_pkg.sv
rtl/bridge_ifs.sv
rtl/uart_hs.sv
rtl/uart_cmd_parser.sv
rtl/mem_arbiter.sv
rtl/reg_mem.sv
rtl/uart_regbridge_top.sv
tb/uart_regbridge_assert.sv
tb/uart_regbridge_tb.sv

/* Makefile */
TOP = uart_regbridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f uart_regbridge.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Test OK" > /dev/null

clean:
	rm -rf obj_dir

/* tb/uart_regbridge_tb.sv */
`timescale 1ns/1ps

module uart_regbridge_tb;
	import uart_regbridge_pkg::*;

	logic              sys_clk;
	logic              sys_rst_n;
	logic              uart_rxd;
	logic              uart_txd;
	logic              host_req;
	logic              host_we;
	logic [addr_w-1:0] host_addr;
	logic [data_w-1:0] host_wdata;
	logic              host_ack;
	logic [data_w-1:0] host_rdata;
	int                value_errs;
	int                timeout_errs;
	int                stop_bits_sent;                  // stop bits driven on uart_rxd

	uart_regbridge_top uart_regbridge_top_i (.*);

	always #4 sys_clk = ~sys_clk;                       // 8 ns period

	task automatic check_byte(input string name, input logic [data_w-1:0] exp,
		input logic [data_w-1:0] got);
		assert (got === exp) else begin
			$display("FAIL %s: expected %h, got %h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic send_byte(input logic [data_w-1:0] b);
		logic [data_w+1:0] frame;
		frame = {1'b1, b, 1'b0};                        // stop, data lsb first, start
		for (int i = 0; i < data_w + 2; i++) begin
			@(posedge sys_clk);
			uart_rxd <= frame[i];
			if (i == data_w + 1)
				stop_bits_sent++;
			repeat (bps_cnt - 1) @(posedge sys_clk);
		end
	endtask

	task automatic wait_host_ack(input logic level);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (host_ack !== level && n < 4 * bps_cnt) begin
			@(negedge sys_clk);
			n++;
		end
		assert (host_ack === level) else begin
			$display("timeout: host_ack never went to %0d", level);
			timeout_errs++;
		end
	endtask

	task automatic host_access(input logic we, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata);
		@(posedge sys_clk);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= addr;
		host_wdata <= wdata;
		wait_host_ack(1'b1);
		rdata = host_rdata;                             // valid while ack is high
		@(posedge sys_clk);
		host_req <= 1'b0;
		wait_host_ack(1'b0);
	endtask

	// frame plus two idle bit periods, so a second frame would show up
	task automatic capture_reply(output logic [data_w-1:0] data);
		logic        line [12 * bps_cnt];
		logic [11:0] frame;
		int          n;
		n = 0;
		@(negedge sys_clk);
		while (uart_txd !== 1'b0 && n < 20 * bps_cnt) begin
			@(negedge sys_clk);
			n++;
		end
		assert (uart_txd === 1'b0) else begin
			$display("timeout: no reply frame started on uart_txd");
			timeout_errs++;
		end
		for (int i = 0; i < 12 * bps_cnt; i++) begin
			line[i] = uart_txd;
			@(negedge sys_clk);
		end
		for (int b = 0; b < 12; b++) begin
			frame[b] = line[b * bps_cnt + bps_cnt_half];    // mid-bit sample
			for (int c = 0; c < bps_cnt; c++)
				assert (line[b * bps_cnt + c] === frame[b]) else begin
					$display("FAIL uart_txd bit %0d cycle %0d: expected %h, got %h",
						b, c, frame[b], line[b * bps_cnt + c]);
					value_errs++;
				end
		end
		assert ({frame[11:9], frame[0]} === 4'b1110) else begin
			$display("FAIL uart_txd framing: expected e, got %h", {frame[11:9], frame[0]});
			value_errs++;
		end
		data = frame[8:1];
	endtask

	task automatic uart_read(input logic [addr_w-1:0] addr, input logic [2:0] spare,
		output logic [data_w-1:0] data);
		fork
			send_byte({1'b0, spare, addr});
			capture_reply(data);
		join
	endtask

	initial begin
		logic [addr_w-1:0] addr_a;
		logic [addr_w-1:0] addr_b;
		logic [data_w-1:0] data_a;
		logic [data_w-1:0] data_b;
		logic [data_w-1:0] rd;
		int                n;
		int                wait_cnt;
		int                bound_errs;
		void'($urandom(32'ha4bbd407));
		{sys_clk, sys_rst_n, host_req, host_we, host_addr, host_wdata} = '0;
		uart_rxd = 1'b1;
		{value_errs, timeout_errs, stop_bits_sent} = '0;
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		assert (uart_txd === 1'b1 && host_ack === 1'b0) else begin
			$display("FAIL idle after reset: uart_txd %h, host_ack %h", uart_txd, host_ack);
			value_errs++;
		end

		addr_a = addr_w'($urandom);                     // uart write, host read back
		data_a = data_w'($urandom);
		send_byte({1'b1, 3'b000, addr_a});
		send_byte(data_a);
		host_access(1'b0, addr_a, '0, rd);
		check_byte("host_rdata", data_a, rd);

		addr_b = addr_w'($urandom);                     // host write, uart read back
		data_b = data_w'($urandom);
		host_access(1'b1, addr_b, data_b, rd);
		uart_read(addr_b, 3'b000, rd);
		check_byte("uart reply", data_b, rd);

		addr_a = addr_w'($urandom);                     // both masters at once
		addr_b = addr_a + addr_w'(1 + $urandom_range(14, 0));
		data_a = data_w'($urandom);
		data_b = data_w'($urandom);
		n = stop_bits_sent + 2;
		fork
			begin
				send_byte({1'b1, 3'b000, addr_a});
				send_byte(data_a);
			end
			begin
				wait_cnt = 0;
				while (stop_bits_sent < n && wait_cnt < 24 * bps_cnt) begin
					@(negedge sys_clk);
					wait_cnt++;
				end
				assert (stop_bits_sent >= n) else begin
					$display("timeout: uart write frames were never sent");
					timeout_errs++;
				end
				repeat (3) @(posedge sys_clk);          // land on the uart access
				host_access(1'b1, addr_b, data_b, rd);
			end
		join
		repeat (bps_cnt) @(posedge sys_clk);
		host_access(1'b0, addr_a, '0, rd);
		check_byte("host_rdata", data_a, rd);
		uart_read(addr_b, 3'b000, rd);
		check_byte("uart reply", data_b, rd);

		addr_a = addr_w'($urandom);                     // bits 6:4 of the command
		data_a = data_w'($urandom);
		host_access(1'b1, addr_a, data_a, rd);
		uart_read(addr_a, 3'b000, rd);
		check_byte("uart reply", data_a, rd);
		uart_read(addr_a, 3'(1 + $urandom_range(6, 0)), rd);
		check_byte("uart reply with bits 6:4 set", data_a, rd);

		bound_errs = uart_regbridge_top_i.uart_regbridge_assert_i.assert_errs;
		$display("done: %0d value errors, %0d timeouts, %0d assertion failures",
			value_errs, timeout_errs, bound_errs);
		if (value_errs == 0 && timeout_errs == 0 && bound_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tb/uart_regbridge_assert.sv */
`timescale 1ns/1ps

module uart_regbridge_assert (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic uart_txd,
	input logic host_req,
	input logic host_ack
);
	logic [2:0] drop_cnt;                               // cycles of ack after req fell
	int         assert_errs = 0;                        // failed assertions so far

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			drop_cnt <= '0;
		else if (host_ack && !host_req)
			drop_cnt <= drop_cnt + 3'd1;
		else
			drop_cnt <= '0;
	end

	a_idle_after_reset: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |-> uart_txd && !host_ack)
		else begin
			$error("uart_txd low or host_ack high right after reset");
			assert_errs++;
		end

	a_ack_needs_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(host_ack) |-> host_req)
		else begin
			$error("host_ack rose without host_req");
			assert_errs++;
		end

	a_ack_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		host_ack && host_req |=> host_ack)
		else begin
			$error("host_ack fell while host_req was still high");
			assert_errs++;
		end

	// arbiter and register file each add a cycle on the way down
	a_ack_drops: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		drop_cnt < 3'd5)
		else begin
			$error("host_ack stayed high too long after host_req fell");
			assert_errs++;
		end

endmodule

bind uart_regbridge_top uart_regbridge_assert uart_regbridge_assert_i (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.uart_txd  (uart_txd),
	.host_req  (host_req),
	.host_ack  (host_ack)
);

/* rtl/uart_regbridge_top.sv */
`timescale 1ns/1ps

module uart_regbridge_top (
	input  logic                                  sys_clk,
	input  logic                                  sys_rst_n,
	input  logic                                  uart_rxd,
	output logic                                  uart_txd,
	input  logic                                  host_req,
	input  logic                                  host_we,
	input  logic [uart_regbridge_pkg::addr_w-1:0] host_addr,
	input  logic [uart_regbridge_pkg::data_w-1:0] host_wdata,
	output logic                                  host_ack,
	output logic [uart_regbridge_pkg::data_w-1:0] host_rdata
);

	byte_if ser_bytes();
	mem_if  uart_bus();                                // parser to arbiter
	mem_if  host_bus();                                // host pins to arbiter
	mem_if  reg_bus();                                 // arbiter to register file

	assign host_bus.req   = host_req;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_ack       = host_bus.ack;
	assign host_rdata     = host_bus.rdata;

	uart_hs uart_hs_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd),
		.byte_port (ser_bytes.uart)
	);

	uart_cmd_parser uart_cmd_parser_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_port (ser_bytes.user),
		.mem_port  (uart_bus.master)
	);

	mem_arbiter mem_arbiter_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_port (uart_bus.slave),
		.host_port (host_bus.slave),
		.mem_port  (reg_bus.master)
	);

	reg_mem reg_mem_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.mem_port  (reg_bus.slave)
	);

endmodule

/* rtl/reg_mem.sv */
`timescale 1ns/1ps

module reg_mem (
	input  logic sys_clk,
	input  logic sys_rst_n,
	mem_if.slave mem_port
);
	import uart_regbridge_pkg::*;

	logic [data_w-1:0] regs [reg_depth];
	logic              ack;
	logic [data_w-1:0] rdata;
	logic              access;

	assign access = mem_port.req & ~ack;               // first cycle of a request

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			regs <= '{default: '0};
			ack  <= 1'b0;
		end else begin
			if (access) begin
				if (mem_port.we)
					regs[mem_port.addr] <= mem_port.wdata;
				ack <= 1'b1;
			end else if (!mem_port.req) begin
				ack <= 1'b0;                            // req gone, close the handshake
			end
		end
	end

	// old contents on a write, read data otherwise
	always_ff @(posedge sys_clk) begin
		if (access)
			rdata <= regs[mem_port.addr];
	end

	assign mem_port.ack   = ack;
	assign mem_port.rdata = rdata;

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	mem_if.slave  uart_port,
	mem_if.slave  host_port,
	mem_if.master mem_port
);
	import uart_regbridge_pkg::*;

	logic              busy;
	logic              last_grant;                  // current owner while busy
	logic              next_grant;
	logic              take;
	logic              gnt_req;
	logic              mem_req;
	logic              mem_we;
	logic [addr_w-1:0] mem_addr;
	logic [data_w-1:0] mem_wdata;
	logic              uart_ack;
	logic              host_ack;
	logic [data_w-1:0] uart_rdata;
	logic [data_w-1:0] host_rdata;

	assign take    = !busy && (uart_port.req || host_port.req);
	assign gnt_req = (last_grant == 1'(port_host)) ? host_port.req : uart_port.req;

	// round robin, the other port wins a tie
	always_comb begin
		if (uart_port.req && host_port.req)
			next_grant = ~last_grant;
		else if (host_port.req)
			next_grant = 1'(port_host);
		else
			next_grant = 1'(port_uart);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy       <= 1'b0;
			last_grant <= 1'(port_host);                // uart first after reset
			mem_req    <= 1'b0;
			uart_ack   <= 1'b0;
			host_ack   <= 1'b0;
		end else begin
			if (take) begin
				busy       <= 1'b1;
				last_grant <= next_grant;
			end else if (busy && !gnt_req && !mem_req && !mem_port.ack) begin
				busy <= 1'b0;                           // both handshakes closed
			end
			mem_req  <= busy & gnt_req;
			uart_ack <= busy && last_grant == 1'(port_uart) && mem_port.ack;
			host_ack <= busy && last_grant == 1'(port_host) && mem_port.ack;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			mem_we    <= (next_grant == 1'(port_host)) ? host_port.we : uart_port.we;
			mem_addr  <= (next_grant == 1'(port_host)) ? host_port.addr : uart_port.addr;
			mem_wdata <= (next_grant == 1'(port_host)) ? host_port.wdata : uart_port.wdata;
		end
		if (mem_port.ack && last_grant == 1'(port_uart))
			uart_rdata <= mem_port.rdata;
		if (mem_port.ack && last_grant == 1'(port_host))
			host_rdata <= mem_port.rdata;
	end

	assign mem_port.req   = mem_req;
	assign mem_port.we    = mem_we;
	assign mem_port.addr  = mem_addr;
	assign mem_port.wdata = mem_wdata;

	assign uart_port.ack   = uart_ack;
	assign uart_port.rdata = uart_rdata;
	assign host_port.ack   = host_ack;
	assign host_port.rdata = host_rdata;

endmodule

/* rtl/uart_cmd_parser.sv */
`timescale 1ns/1ps

module uart_cmd_parser (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	byte_if.user  byte_port,
	mem_if.master mem_port
);
	import uart_regbridge_pkg::*;

	logic [st_w-1:0]   state;
	logic [data_w-1:0] cmd;                            // last command byte
	logic              req;
	logic              tx_en;
	logic [data_w-1:0] wdata;
	logic [data_w-1:0] tx_data;
	logic              rx_take;
	logic              rd_done;

	// bytes are dropped while a reply is still on the line
	assign rx_take = byte_port.rx_valid & ~byte_port.tx_busy;
	assign rd_done = state == st_access && mem_port.ack && !cmd[cmd_wr_bit];

	assign mem_port.req   = req;
	assign mem_port.we    = cmd[cmd_wr_bit];
	assign mem_port.addr  = cmd[addr_w-1:0];         // upper bits ignored
	assign mem_port.wdata = wdata;

	assign byte_port.tx_en   = tx_en;
	assign byte_port.tx_data = tx_data;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_cmd;
			cmd   <= '0;
			req   <= 1'b0;
			tx_en <= 1'b0;
		end else begin
			case (state)
				st_cmd: begin
					if (rx_take) begin
						cmd <= byte_port.rx_data;
						if (byte_port.rx_data[cmd_wr_bit]) begin
							state <= st_data;
						end else begin
							req   <= 1'b1;          // read goes out right away
							state <= st_access;
						end
					end
				end
				st_data: begin
					if (rx_take) begin
						req   <= 1'b1;
						state <= st_access;
					end
				end
				st_access: begin
					if (mem_port.ack) begin
						req <= 1'b0;
						if (cmd[cmd_wr_bit]) begin
							state <= st_cmd;        // writes send nothing back
						end else begin
							tx_en <= 1'b1;
							state <= st_reply;
						end
					end
				end
				st_reply: begin
					if (byte_port.tx_busy) begin
						tx_en <= 1'b0;
						state <= st_wait_end;
					end
				end
				st_wait_end: begin
					if (!byte_port.tx_busy)
						state <= st_cmd;
				end
				default: state <= st_cmd;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_data && rx_take)
			wdata <= byte_port.rx_data;
		if (rd_done)
			tx_data <= mem_port.rdata;              // reply byte
	end

endmodule

/* rtl/uart_hs.sv */
`timescale 1ns/1ps

module uart_hs (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic uart_rxd,
	output logic uart_txd,
	byte_if.uart byte_port
);
	import uart_regbridge_pkg::*;

	logic              tx_en_d0;
	logic              tx_en_d1;
	logic              tx_en_d2;
	logic              tx_start;
	logic              tx_flag;
	logic [data_w-1:0] tx_buf;
	logic [cnt_w-1:0]  tx_clk_cnt;
	logic [bit_w-1:0]  tx_cnt;

	logic              rxd_d0;
	logic              rxd_d1;
	logic              rx_start;
	logic              rx_flag;
	logic              rx_done;
	logic [cnt_w-1:0]  rx_clk_cnt;
	logic [bit_w-1:0]  rx_cnt;
	logic [data_w-1:0] rx_shift;

	assign tx_start = tx_en_d1 & ~tx_en_d2 & ~tx_flag;    // rising edge of tx_en
	assign byte_port.tx_busy = tx_flag;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_en_d0 <= 1'b0;
			tx_en_d1 <= 1'b0;
			tx_en_d2 <= 1'b0;
		end else begin
			tx_en_d0 <= byte_port.tx_en;
			tx_en_d1 <= tx_en_d0;
			tx_en_d2 <= tx_en_d1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			tx_flag <= 1'b0;
		else if (tx_start)
			tx_flag <= 1'b1;
		else if (tx_cnt == bit_w'(stop_idx) && tx_clk_cnt == cnt_w'(bps_cnt_half))
			tx_flag <= 1'b0;                            // done at middle of stop bit
	end

	always_ff @(posedge sys_clk) begin
		if (tx_start)
			tx_buf <= byte_port.tx_data;                // hold byte for the whole frame
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_clk_cnt <= '0;
			tx_cnt     <= '0;
		end else if (tx_flag) begin
			if (tx_clk_cnt == cnt_w'(bps_cnt - 1)) begin
				tx_clk_cnt <= '0;
				tx_cnt     <= tx_cnt + 1'b1;            // next bit of the frame
			end else begin
				tx_clk_cnt <= tx_clk_cnt + 1'b1;
			end
		end else begin
			tx_clk_cnt <= '0;
			tx_cnt     <= '0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			uart_txd <= 1'b1;
		end else if (tx_flag) begin
			case (tx_cnt)
				4'd0:             uart_txd <= 1'b0;      // start bit
				bit_w'(stop_idx): uart_txd <= 1'b1;
				default:          uart_txd <= tx_buf[3'(tx_cnt - 1'b1)];    // lsb first
			endcase
		end else begin
			uart_txd <= 1'b1;                           // idle high
		end
	end

	// receiver, start edge taken after the two-flop synchronizer
	assign rx_start = rxd_d1 & ~rxd_d0 & ~rx_flag;
	assign rx_done  = rx_flag && rx_cnt == bit_w'(stop_idx) && rx_clk_cnt == '0;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_d0 <= 1'b1;
			rxd_d1 <= 1'b1;
		end else begin
			rxd_d0 <= uart_rxd;
			rxd_d1 <= rxd_d0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_flag <= 1'b0;
		else if (rx_start)
			rx_flag <= 1'b1;
		else if (rx_cnt == bit_w'(stop_idx) && rx_clk_cnt == cnt_w'(bps_cnt_half))
			rx_flag <= 1'b0;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_clk_cnt <= '0;
			rx_cnt     <= '0;
		end else if (rx_flag) begin
			if (rx_clk_cnt == cnt_w'(bps_cnt - 1)) begin
				rx_clk_cnt <= '0;
				rx_cnt     <= rx_cnt + 1'b1;
			end else begin
				rx_clk_cnt <= rx_clk_cnt + 1'b1;
			end
		end else begin
			rx_clk_cnt <= '0;
			rx_cnt     <= '0;
		end
	end

	// data bits 1..8 shift in from the top, so bit 0 ends up first received
	always_ff @(posedge sys_clk) begin
		if (rx_flag && rx_clk_cnt == cnt_w'(bps_cnt_half) &&
			rx_cnt != '0 && rx_cnt < bit_w'(stop_idx))
			rx_shift <= {rxd_d1, rx_shift[data_w-1:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			byte_port.rx_valid <= 1'b0;
		else
			byte_port.rx_valid <= rx_done;              // one pulse per frame
	end

	always_ff @(posedge sys_clk) begin
		if (rx_done)
			byte_port.rx_data <= rx_shift;
	end

endmodule

/* rtl/bridge_ifs.sv */
`timescale 1ns/1ps

interface mem_if;
	import uart_regbridge_pkg::*;

	logic              req;
	logic              ack;
	logic              we;                           // 1 = write
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic [data_w-1:0] rdata;                        // valid while ack is high

	modport master (output req, output we, output addr, output wdata,
		input ack, input rdata);
	modport slave (input req, input we, input addr, input wdata,
		output ack, output rdata);
endinterface

interface byte_if;
	import uart_regbridge_pkg::*;

	logic              rx_valid;                     // single cycle
	logic [data_w-1:0] rx_data;
	logic              tx_en;                        // rising edge starts a frame
	logic [data_w-1:0] tx_data;
	logic              tx_busy;

	modport uart (output rx_valid, output rx_data, output tx_busy,
		input tx_en, input tx_data);
	modport user (input rx_valid, input rx_data, input tx_busy,
		output tx_en, output tx_data);
endinterface

/* rtl/uart_regbridge_pkg.sv */
package uart_regbridge_pkg;

	// bit timing, 50 MHz sys_clk at 2 Mbaud
	localparam int bps_cnt      = 25;                 // clocks per bit
	localparam int bps_cnt_half = 12;                 // mid-bit sample point
	localparam int cnt_w        = $clog2(bps_cnt);    // bit timer width
	localparam int bit_w        = 4;                  // start, 8 data, stop
	localparam int stop_idx     = 9;                  // frame index of the stop bit

	// register file geometry
	localparam int addr_w    = 4;
	localparam int data_w    = 8;
	localparam int reg_depth = 1 << addr_w;

	// command byte layout, bits 6:4 are don't care
	localparam int cmd_wr_bit = 7;                    // 1 = write, 0 = read

	// arbiter port numbering
	localparam int port_uart = 0;
	localparam int port_host = 1;

	// command parser states
	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_cmd      = 3'd0;   // wait for command byte
	localparam logic [st_w-1:0] st_data     = 3'd1;   // wait for write data
	localparam logic [st_w-1:0] st_access   = 3'd2;   // four-phase access running
	localparam logic [st_w-1:0] st_reply    = 3'd3;   // tx_en held until busy
	localparam logic [st_w-1:0] st_wait_end = 3'd4;   // reply frame on the line

endpackage
